/* build.f */
+incdir+hdl
hdl/frame_pkg.sv
hdl/cam_capture.sv
hdl/wb_arbiter.sv
hdl/frame_ram.sv
hdl/video_reader.sv
hdl/dual_cam_frame_top.sv
dv/tb_dual_cam.sv

/* Bender.yml */
package:
  name: dual_cam_frame

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/frame_pkg.sv
      - hdl/cam_capture.sv
      - hdl/wb_arbiter.sv
      - hdl/frame_ram.sv
      - hdl/video_reader.sv
      - hdl/dual_cam_frame_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tb_dual_cam.sv

/* dv/tb_dual_cam.sv */
`timescale 1ns/1ps
`default_nettype none
`include "frame_macros.svh"

module tb_dual_cam;

    localparam int CLK_NS      = 20;
    localparam int IDLE_CYC    = 8;                       // gap after each byte pair
    localparam int PIX_CYC     = IDLE_CYC + 2;            // cycles per camera pixel
    localparam int JUNK_PIX    = 3;                       // pixels before first vsync
    localparam int FRAME_WORDS = `CAM_FRAME_WORDS;
    localparam int BEATS       = 2 * FRAME_WORDS;         // side-by-side readout
    localparam int NUM_FRAMES  = 2;
    localparam int CAP_CYC     = (JUNK_PIX + FRAME_WORDS) * PIX_CYC + 4;
    localparam int RD_CYC      = BEATS * 4 + 4;           // req, grant, access, ack
    localparam int DRAIN_LIMIT = 64;
    localparam int TOTAL_CYC   = NUM_FRAMES * (CAP_CYC + RD_CYC + DRAIN_LIMIT) + 8;
    localparam int WATCHDOG_NS = 4 * TOTAL_CYC * CLK_NS;

    logic              sys_clk;
    logic              rst;
    logic              cam_vsync_1;
    logic              cam_href_1;
    logic [7:0]        cam_data_1;
    logic              cam_vsync_2;
    logic              cam_href_2;
    logic [7:0]        cam_data_2;
    logic              rd_start;
    logic              video_de;
    logic              video_vs;
    logic [`RGB_W-1:0] video_rgb;
    logic              frame_done;

    logic [`PIX_W-1:0] model_pix [2][FRAME_WORDS];        // [camera][row*8+col]
    string             test_name;
    int                beat_idx;
    logic              prev_last;                         // last beat seen one cycle ago
    logic [1:0]        vsync_seen;                        // per camera, frame start driven
    logic [`RGB_W-1:0] exp_rgb;

    dual_cam_frame_top dut (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .cam_vsync_1 (cam_vsync_1),
        .cam_href_1  (cam_href_1),
        .cam_data_1  (cam_data_1),
        .cam_vsync_2 (cam_vsync_2),
        .cam_href_2  (cam_href_2),
        .cam_data_2  (cam_data_2),
        .rd_start    (rd_start),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_rgb   (video_rgb),
        .frame_done  (frame_done)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_NS / 2) sys_clk = ~sys_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run took too long");
        $display("Test FAILED");
        $fatal(1);
    end

    //**********************************************************************
    // helpers
    //**********************************************************************
    task automatic step;
        @(posedge sys_clk);
        #2;                                               // inputs move after the edge
    endtask

    task automatic report_mismatch(input string what, input logic [23:0] exp,
                                   input logic [23:0] act);
        $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        $display("Test FAILED");
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
    endtask

    // byte pair to rgb888, low bits of each channel zero
    function automatic logic [23:0] rgb_from_565(input logic [15:0] p);
        logic [7:0] hi;
        logic [7:0] lo;
        hi = p[15:8];                                     // first byte on the camera bus
        lo = p[7:0];
        return {hi & 8'hF8,                               // red, top of high byte
                hi[2:0], lo[7:5], 2'b00,                  // green spans both bytes
                lo[4:0], 3'b000};
    endfunction

    // beat k of the readout, cam 1 row then cam 2 row
    function automatic logic [15:0] pixel_at_beat(input int k);
        int row;
        int side;
        int col;
        row  = k / (2 * `CAM_H_PIX);
        side = (k / `CAM_H_PIX) % 2;
        col  = k % `CAM_H_PIX;
        return model_pix[side][row * `CAM_H_PIX + col];
    endfunction

    task automatic set_cam(input int cam, input logic vs, input logic hr,
                           input logic [7:0] d);
        if (cam == 0) begin
            cam_vsync_1 = vs;
            cam_href_1  = hr;
            cam_data_1  = d;
        end else begin
            cam_vsync_2 = vs;
            cam_href_2  = hr;
            cam_data_2  = d;
        end
    endtask

    task automatic send_pixel(input int cam, input logic [15:0] pix);
        set_cam(cam, 1'b0, 1'b1, pix[15:8]);              // high byte first
        step();
        set_cam(cam, 1'b0, 1'b1, pix[7:0]);
        step();
        set_cam(cam, 1'b0, 1'b0, 8'h00);
        repeat (IDLE_CYC) step();                         // lets the fifo drain
    endtask

    task automatic drive_frame(input int cam, input int n_junk);
        for (int i = 0; i < n_junk; i++)
            send_pixel(cam, 16'hA5C3 ^ 16'(i * 37));     // must never show up
        set_cam(cam, 1'b1, 1'b0, 8'h00);
        step();
        set_cam(cam, 1'b0, 1'b0, 8'h00);
        step();
        for (int i = 0; i < FRAME_WORDS; i++)
            send_pixel(cam, model_pix[cam][i]);
    endtask

    task automatic wait_capture_idle;
        int n;
        n = 0;
        while ((dut.m_cyc[1:0] != 2'b00 || !dut.u_cam_capture_1.fifo_empty ||
                !dut.u_cam_capture_2.fifo_empty) && n < DRAIN_LIMIT) begin
            step();
            n++;
        end
        assert (n < DRAIN_LIMIT) else begin
            report_problem("capture writes never finished on the bus");
            $fatal(1);
        end
    endtask

    task automatic read_frame;
        int n;
        n        = 0;
        beat_idx = 0;
        rd_start = 1'b1;                                  // one-cycle pulse
        step();
        rd_start = 1'b0;
        while (!frame_done && n < 2 * RD_CYC) begin
            step();
            n++;
        end
        assert (n < 2 * RD_CYC) else begin
            report_problem("frame_done never came after rd_start");
            $fatal(1);
        end
        assert (beat_idx == BEATS) else begin
            report_mismatch("beat count", 24'(BEATS), 24'(beat_idx));
            $fatal(1);
        end
        step();
    endtask

    //**********************************************************************
    // output checker, sampled mid-cycle
    //**********************************************************************
    always @(negedge sys_clk) begin
        if (!rst) begin
            if (cam_vsync_1)
                vsync_seen[0] = 1'b1;
            if (cam_vsync_2)
                vsync_seen[1] = 1'b1;
            // bytes before the first vsync must not reach memory
            assert ((dut.m_cyc[1:0] & ~vsync_seen) == 2'b00) else begin
                report_problem("a camera wrote to memory before its first vsync");
                $fatal(1);
            end
            if (video_de) begin
                assert (beat_idx < BEATS) else begin
                    report_problem("more pixel beats than one frame holds");
                    $fatal(1);
                end
                exp_rgb = rgb_from_565(pixel_at_beat(beat_idx));
                assert (video_rgb === exp_rgb) else begin
                    report_mismatch($sformatf("pixel %0d", beat_idx), exp_rgb, video_rgb);
                    $fatal(1);
                end
                assert (video_vs === (beat_idx == 0)) else begin
                    report_mismatch("video_vs", 24'(beat_idx == 0), 24'(video_vs));
                    $fatal(1);
                end
                beat_idx++;
            end else begin
                assert (video_vs === 1'b0) else begin
                    report_problem("video_vs high without video_de");
                    $fatal(1);
                end
            end
            assert (frame_done === prev_last) else begin
                report_mismatch("frame_done", 24'(prev_last), 24'(frame_done));
                $fatal(1);
            end
            prev_last = video_de && (beat_idx == BEATS);
        end
    end

    //**********************************************************************
    // main sequence
    //**********************************************************************
    initial begin
        void'($urandom(88836));
        rst         = 1'b1;
        rd_start    = 1'b0;
        cam_vsync_1 = 1'b0;
        cam_href_1  = 1'b0;
        cam_data_1  = 8'h00;
        cam_vsync_2 = 1'b0;
        cam_href_2  = 1'b0;
        cam_data_2  = 8'h00;
        beat_idx    = 0;
        prev_last   = 1'b0;
        vsync_seen  = 2'b00;
        test_name   = "reset";
        repeat (2) @(posedge sys_clk);
        #2;
        rst = 1'b0;
        @(negedge sys_clk);
        assert ({video_de, video_vs, frame_done} === 3'b000) else begin
            report_mismatch("outputs after reset", 24'h0, 24'({video_de, video_vs, frame_done}));
            $fatal(1);
        end
        step();

        for (int f = 0; f < NUM_FRAMES; f++) begin
            test_name = $sformatf("frame%0d", f + 1);
            for (int c = 0; c < 2; c++)
                for (int i = 0; i < FRAME_WORDS; i++)
                    model_pix[c][i] = 16'($urandom);
            fork                                          // both cameras at once
                drive_frame(0, (f == 0) ? JUNK_PIX : 0);
                drive_frame(1, (f == 0) ? JUNK_PIX : 0);
            join
            wait_capture_idle();
            read_frame();                                 // frame 2 must replace frame 1
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/dual_cam_frame_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "frame_macros.svh"

module dual_cam_frame_top (
    input  wire               sys_clk,
    input  wire               rst,
    input  wire               cam_vsync_1,
    input  wire               cam_href_1,
    input  wire [7:0]         cam_data_1,
    input  wire               cam_vsync_2,
    input  wire               cam_href_2,
    input  wire [7:0]         cam_data_2,
    input  wire               rd_start,
    output wire               video_de,
    output wire               video_vs,
    output wire [`RGB_W-1:0]  video_rgb,
    output wire               frame_done
);
    import frame_pkg::*;

    // master side, indexed by master_t
    wire [2:0]              m_cyc;
    wire [2:0]              m_stb;
    wire [2:0]              m_we;
    wire [3*`WB_ADR_W-1:0]  m_adr;
    wire [3*`PIX_W-1:0]     m_dat_w;
    wire [2:0]              m_ack;
    wire [`PIX_W-1:0]       m_dat_r;
    // slave side
    wire                    s_cyc;
    wire                    s_stb;
    wire                    s_we;
    wire [`WB_ADR_W-1:0]    s_adr;
    wire [`PIX_W-1:0]       s_dat_w;
    wire                    s_ack;
    wire [`PIX_W-1:0]       s_dat_r;

    assign m_dat_w[MST_READ*`PIX_W +: `PIX_W] = '0; // reader never writes

    //**********************************************************************
    // bus masters
    //**********************************************************************
    cam_capture #(.BASE_ADDR(`WB_ADR_W'(`CAM1_BASE))) u_cam_capture_1 (
        .sys_clk (sys_clk),                .rst      (rst),
        .cam_vsync (cam_vsync_1),          .cam_href (cam_href_1),
        .cam_data (cam_data_1),            .wb_ack   (m_ack[MST_CAM1]),
        .wb_cyc  (m_cyc[MST_CAM1]),        .wb_stb   (m_stb[MST_CAM1]),
        .wb_we   (m_we[MST_CAM1]),
        .wb_adr  (m_adr[MST_CAM1*`WB_ADR_W +: `WB_ADR_W]),
        .wb_dat_w (m_dat_w[MST_CAM1*`PIX_W +: `PIX_W])
    );

    cam_capture #(.BASE_ADDR(`WB_ADR_W'(`CAM2_BASE))) u_cam_capture_2 (
        .sys_clk (sys_clk),                .rst      (rst),
        .cam_vsync (cam_vsync_2),          .cam_href (cam_href_2),
        .cam_data (cam_data_2),            .wb_ack   (m_ack[MST_CAM2]),
        .wb_cyc  (m_cyc[MST_CAM2]),        .wb_stb   (m_stb[MST_CAM2]),
        .wb_we   (m_we[MST_CAM2]),
        .wb_adr  (m_adr[MST_CAM2*`WB_ADR_W +: `WB_ADR_W]),
        .wb_dat_w (m_dat_w[MST_CAM2*`PIX_W +: `PIX_W])
    );

    video_reader u_video_reader (
        .sys_clk (sys_clk),                .rst      (rst),
        .rd_start (rd_start),              .wb_ack   (m_ack[MST_READ]),
        .wb_dat_r (m_dat_r),               .wb_cyc   (m_cyc[MST_READ]),
        .wb_stb  (m_stb[MST_READ]),        .wb_we    (m_we[MST_READ]),
        .wb_adr  (m_adr[MST_READ*`WB_ADR_W +: `WB_ADR_W]),
        .video_de (video_de),              .video_vs (video_vs),
        .video_rgb (video_rgb),            .frame_done (frame_done)
    );

    //**********************************************************************
    // shared bus and frame memory
    //**********************************************************************
    wb_arbiter #(.ADR_W(`WB_ADR_W), .DAT_W(`PIX_W)) u_wb_arbiter (
        .sys_clk (sys_clk),  .rst     (rst),
        .m_cyc   (m_cyc),    .m_stb   (m_stb),   .m_we  (m_we),
        .m_adr   (m_adr),    .m_dat_w (m_dat_w), .m_ack (m_ack),
        .m_dat_r (m_dat_r),  .s_ack   (s_ack),   .s_dat_r (s_dat_r),
        .s_cyc   (s_cyc),    .s_stb   (s_stb),   .s_we  (s_we),
        .s_adr   (s_adr),    .s_dat_w (s_dat_w)
    );

    frame_ram u_frame_ram (
        .sys_clk (sys_clk),  .rst      (rst),
        .wb_cyc  (s_cyc),    .wb_stb   (s_stb),   .wb_we (s_we),
        .wb_adr  (s_adr),    .wb_dat_w (s_dat_w),
        .wb_ack  (s_ack),    .wb_dat_r (s_dat_r)
    );

endmodule

`default_nettype wire

/* hdl/video_reader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "frame_macros.svh"

module video_reader (
    input  logic                 sys_clk,
    input  logic                 rst,
    input  logic                 rd_start,     // frame request
    input  logic                 wb_ack,
    input  logic [`PIX_W-1:0]    wb_dat_r,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [`WB_ADR_W-1:0] wb_adr,
    output logic                 video_de,
    output logic                 video_vs,     // with first de of the frame
    output logic [`RGB_W-1:0]    video_rgb,
    output logic                 frame_done
);
    import frame_pkg::*;

    localparam int COL_W = $clog2(`CAM_H_PIX);
    localparam int ROW_W = $clog2(`CAM_V_PIX);

    rd_state_t        state;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             side;                    // 0 cam 1, 1 cam 2
    logic             first;                   // next beat opens the frame
    logic             last_pix;
    logic             beat;
    logic             last_beat;               // video_de carries last pixel

    assign last_pix = (row == ROW_W'(`CAM_V_PIX - 1)) && side &&
                      (col == COL_W'(`CAM_H_PIX - 1));
    assign beat     = (state == WAIT_ACK) && wb_ack;

    //******************************************************************
    // read sequencer, raster order with cam 1 row then cam 2 row
    //******************************************************************
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state <= IDLE;
            col   <= '0;
            row   <= '0;
            side  <= 1'b0;
            first <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_start) begin
                        state <= REQ;
                        col   <= '0;
                        row   <= '0;
                        side  <= 1'b0;
                        first <= 1'b1;
                    end
                end
                REQ: state <= WAIT_ACK;        // cyc rises here
                WAIT_ACK: begin
                    if (wb_ack) begin
                        first <= 1'b0;
                        state <= last_pix ? IDLE : REQ;
                        col   <= col + 1'b1;   // wraps at row end
                        if (col == COL_W'(`CAM_H_PIX - 1)) begin
                            side <= !side;
                            if (side)
                                row <= row + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign wb_cyc = (state == WAIT_ACK);
    assign wb_stb = wb_cyc;
    assign wb_we  = 1'b0;                      // read-only master
    assign wb_adr = (side ? `WB_ADR_W'(`CAM2_BASE) : `WB_ADR_W'(`CAM1_BASE)) +
                    `WB_ADR_W'(row * `CAM_H_PIX) + `WB_ADR_W'(col);

    //******************************************************************
    // pixel output
    //******************************************************************
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            video_de   <= 1'b0;
            video_vs   <= 1'b0;
            last_beat  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            video_de   <= beat;
            video_vs   <= beat && first;
            last_beat  <= beat && last_pix;
            frame_done <= last_beat;           // one cycle after last pixel
        end
    end

    always_ff @(posedge sys_clk) begin
        if (beat)                              // rgb565, zero-filled low bits
            video_rgb <= {wb_dat_r[15:11], 3'b000, wb_dat_r[10:5], 2'b00,
                          wb_dat_r[4:0], 3'b000};
    end

endmodule

`default_nettype wire

/* hdl/frame_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "frame_macros.svh"

module frame_ram (
    input  logic                 sys_clk,
    input  logic                 rst,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`WB_ADR_W-1:0] wb_adr,
    input  logic [`PIX_W-1:0]    wb_dat_w,
    output logic                 wb_ack,
    output logic [`PIX_W-1:0]    wb_dat_r
);

    localparam int DEPTH = 1 << `WB_ADR_W;     // both camera regions

    logic [`PIX_W-1:0] mem [DEPTH];
    logic              access;

    assign access = wb_cyc && wb_stb && !wb_ack; // no second ack on a held cycle

    always_ff @(posedge sys_clk) begin
        if (rst)
            wb_ack <= 1'b0;
        else
            wb_ack <= access;                  // one cycle stb to ack
    end

    always_ff @(posedge sys_clk) begin
        if (access) begin
            if (wb_we)
                mem[wb_adr] <= wb_dat_w;
            wb_dat_r <= mem[wb_adr];           // valid in the ack cycle
        end
    end

endmodule

`default_nettype wire

/* hdl/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter #(
    parameter int ADR_W = 6,
    parameter int DAT_W = 16
) (
    input  logic               sys_clk,
    input  logic               rst,
    input  logic [2:0]         m_cyc,
    input  logic [2:0]         m_stb,
    input  logic [2:0]         m_we,
    input  logic [3*ADR_W-1:0] m_adr,     // master i at [i*ADR_W +: ADR_W]
    input  logic [3*DAT_W-1:0] m_dat_w,
    input  logic               s_ack,
    input  logic [DAT_W-1:0]   s_dat_r,
    output logic [2:0]         m_ack,
    output logic [DAT_W-1:0]   m_dat_r,
    output logic               s_cyc,
    output logic               s_stb,
    output logic               s_we,
    output logic [ADR_W-1:0]   s_adr,
    output logic [DAT_W-1:0]   s_dat_w
);
    import frame_pkg::*;

    logic    busy;                             // owner holds the bus
    master_t owner;
    master_t last;                             // round-robin pointer
    master_t pick;                             // next grant candidate
    logic    any_req;

    // first requester after the last owner
    always_comb begin
        int cand;
        pick = last;
        for (int i = 3; i >= 1; i--) begin     // lowest offset wins, so scan down
            cand = (int'(last) + i) % 3;
            if (m_cyc[cand])
                pick = master_t'(cand);
        end
    end

    assign any_req = |m_cyc;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            busy  <= 1'b0;
            owner <= MST_CAM1;
            last  <= MST_READ;                 // camera 1 served first
        end else if (!busy || !m_cyc[owner]) begin
            busy <= any_req;                   // re-arbitrate once cyc drops
            if (any_req) begin
                owner <= pick;
                last  <= pick;
            end
        end
    end

    // owner request to the slave, ack back to the owner only
    assign s_cyc   = busy && m_cyc[owner];
    assign s_stb   = busy && m_stb[owner];
    assign s_we    = m_we[owner];
    assign s_adr   = m_adr[owner*ADR_W +: ADR_W];
    assign s_dat_w = m_dat_w[owner*DAT_W +: DAT_W];
    assign m_ack   = busy ? (3'(s_ack) << owner) : 3'b000;
    assign m_dat_r = busy ? s_dat_r : '0;

endmodule

`default_nettype wire

/* hdl/cam_capture.sv */
`timescale 1ns/1ps
`default_nettype none
`include "frame_macros.svh"

module cam_capture #(
    parameter logic [`WB_ADR_W-1:0] BASE_ADDR = `WB_ADR_W'(`CAM1_BASE)
) (
    input  logic                 sys_clk,
    input  logic                 rst,
    input  logic                 cam_vsync,   // frame start
    input  logic                 cam_href,    // line valid
    input  logic [7:0]           cam_data,    // byte stream
    input  logic                 wb_ack,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [`WB_ADR_W-1:0] wb_adr,
    output logic [`PIX_W-1:0]    wb_dat_w
);
    import frame_pkg::*;

    localparam int CNT_W = $clog2(`CAM_FRAME_WORDS + 1); // must reach frame size
    localparam int PTR_W = $clog2(`PIX_FIFO_DEPTH);
    localparam int ENT_W = `WB_ADR_W + `PIX_W;           // {adr, pixel}

    cap_state_t       state;
    byte_phase_t      phase;
    logic [7:0]       hi_byte;                   // first byte of the pair
    logic [CNT_W-1:0] pix_cnt;                   // pixels in this frame
    logic             pix_vld;                   // pix_ent ready to push
    logic [ENT_W-1:0] pix_ent;

    logic [ENT_W-1:0] fifo_mem [`PIX_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fifo_cnt;
    logic             fifo_full;
    logic             fifo_empty;
    logic             push;
    logic             pop;

    //******************************************************************
    // byte pairing and frame tracking
    //******************************************************************
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state   <= WAIT_FRAME;
            phase   <= HIGH_BYTE;
            pix_cnt <= '0;
            pix_vld <= 1'b0;
        end else begin
            pix_vld <= 1'b0;                     // single-cycle strobe
            if (cam_vsync) begin
                state   <= ACTIVE;               // count restarts every frame
                phase   <= HIGH_BYTE;
                pix_cnt <= '0;
            end else if (state == ACTIVE && cam_href) begin
                if (phase == HIGH_BYTE) begin
                    phase <= LOW_BYTE;
                end else begin
                    phase <= HIGH_BYTE;
                    if (pix_cnt < CNT_W'(`CAM_FRAME_WORDS)) begin
                        pix_vld <= 1'b1;         // overflow pixels dropped
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end
            end else begin
                phase <= HIGH_BYTE;              // realign at each line
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == ACTIVE && cam_href && !cam_vsync) begin
            if (phase == HIGH_BYTE)
                hi_byte <= cam_data;
            else
                pix_ent <= {BASE_ADDR + `WB_ADR_W'(pix_cnt), hi_byte, cam_data};
        end
    end

    //******************************************************************
    // pixel fifo
    //******************************************************************
    assign fifo_full  = (fifo_cnt == (PTR_W+1)'(`PIX_FIFO_DEPTH));
    assign fifo_empty = (fifo_cnt == '0);
    assign push       = pix_vld && !fifo_full;   // full fifo drops the pixel
    assign pop        = wb_cyc && wb_ack;        // head written

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            fifo_cnt <= fifo_cnt + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (push)
            fifo_mem[wr_ptr] <= pix_ent;
    end

    // bus write master, one idle cycle after every ack
    always_ff @(posedge sys_clk) begin
        if (rst)
            wb_cyc <= 1'b0;
        else if (wb_cyc)
            wb_cyc <= !wb_ack;                   // drop right after ack
        else
            wb_cyc <= !fifo_empty;
    end

    assign wb_stb             = wb_cyc;
    assign wb_we              = wb_cyc;          // write-only master
    assign {wb_adr, wb_dat_w} = fifo_mem[rd_ptr]; // head stable until pop

endmodule

`default_nettype wire

/* hdl/frame_pkg.sv */
`default_nettype none

package frame_pkg;

    //******************************************************************
    // capture channel
    //******************************************************************
    typedef enum logic {
        WAIT_FRAME,                 // no vsync seen yet
        ACTIVE                      // inside a frame, pixels counted
    } cap_state_t;

    typedef enum logic {
        HIGH_BYTE,                  // r[4:0], g[5:3]
        LOW_BYTE                    // g[2:0], b[4:0]
    } byte_phase_t;

    //******************************************************************
    // readout and bus
    //******************************************************************
    typedef enum logic [1:0] {
        IDLE,                       // waiting for rd_start
        REQ,                        // bus idle cycle, raise cyc at its end
        WAIT_ACK                    // cyc/stb held until ack
    } rd_state_t;

    // arbiter port index of each bus master
    typedef enum logic [1:0] {
        MST_CAM1 = 2'd0,
        MST_CAM2 = 2'd1,
        MST_READ = 2'd2
    } master_t;

endpackage

`default_nettype wire

/* hdl/frame_macros.svh */
`ifndef FRAME_MACROS_SVH
`define FRAME_MACROS_SVH

//**********************************************************************
// frame geometry
//**********************************************************************
`define CAM_H_PIX        8                        // pixels per camera row
`define CAM_V_PIX        4                        // rows per frame
`define CAM_FRAME_WORDS  (`CAM_H_PIX * `CAM_V_PIX) // words per camera region

// word addresses of the two regions in frame memory
`define CAM1_BASE        0                        // camera 1 region
`define CAM2_BASE        32                       // camera 2 region, right after cam 1

//**********************************************************************
// bus and pixel widths
//**********************************************************************
`define WB_ADR_W         6                        // 64-word frame memory
`define PIX_W            16                       // rgb565
`define RGB_W            24                       // rgb888 after expansion

// capture buffering
`define PIX_FIFO_DEPTH   4                        // covers worst arbitration wait

`endif
